/* source/dsi_csr_pkg.sv */
`default_nettype none

package dsi_csr_pkg;

   // host bus widths
   localparam int csr_addr_bits = 6;
   localparam int csr_data_bits = 32;

   localparam int tick_div_bits = 12;
   localparam int gpio_bits     = 3;

   typedef enum logic [csr_addr_bits-1:0] {
      REG_TICK_DIV  = 6'h00,
      REG_DSI_CTL   = 6'h01,
      REG_LP_TX     = 6'h02,
      REG_GPIO      = 6'h03,
      REG_LANE_CTRL = 6'h04
   } csr_addr_e;

   // DSI_CTL, bit 1 reads back as lp ready
   localparam int ctl_clk_en_bit = 0;
   localparam int ctl_lp_req_bit = 1;

   // LP_TX
   localparam int lp_tx_data_lsb  = 0;
   localparam int lp_tx_data_bits = 8;
   localparam int lp_tx_valid_bit = 8;

   // GPIO
   localparam int gpio_reset_bit = 0;
   localparam int gpio_lsb       = 1;

   // LANE_CTRL, 2-bit selects packed from bit 0
   localparam int lane_sel_lsb  = 0;
   localparam int lane_sel_bits = 2;
   localparam int lane_inv_lsb  = 8;
   localparam int clk_inv_bit   = 12;

endpackage

`default_nettype wire

/* source/dsi_phy_pkg.sv */
`default_nettype none

package dsi_phy_pkg;

   // one serdes byte per clk_dsi_i cycle
   localparam int lane_byte_bits    = 8;
   localparam int lane_bit_cnt_bits = 3;

   // toggling pattern for the HS clock lane
   localparam logic [lane_byte_bits-1:0] clk_hs_pattern = 8'haa;

   // LP-11 stop state on both pins
   localparam logic lp_stop_line = 1'b1;
   // LP-00 while the HS driver owns the pins
   localparam logic lp_hs_line   = 1'b0;

   typedef enum logic {
      LP_STOP,
      LP_SHIFT
   } lp_lane_state_e;

   typedef enum logic [1:0] {
      CLK_LP,
      CLK_HS_REQ,
      CLK_HS
   } clk_lane_state_e;

endpackage

`default_nettype wire

/* source/dsi_lane_ctrl_if.sv */
`default_nettype none

interface dsi_lane_ctrl_if #(
   parameter int lanes_p = 3
) ();

   logic                                            tick;
   logic                                            lp_request;
   logic                                            lp_valid;
   logic [dsi_phy_pkg::lane_byte_bits-1:0]          lp_data;
   logic [lanes_p*dsi_csr_pkg::lane_sel_bits-1:0]   lane_sel;
   logic [lanes_p-1:0]                              lane_invert;
   // only lane 0 drives this
   logic                                            lp_ready;

   modport regs (
      output tick, lp_request, lp_valid, lp_data, lane_sel, lane_invert,
      input  lp_ready
   );

   modport lane (
      input  tick, lp_request, lp_valid, lp_data, lane_sel, lane_invert,
      output lp_ready
   );

endinterface

`default_nettype wire

/* source/dsi_host_regs.sv */
`default_nettype none

module dsi_host_regs #(
   parameter int lanes_p = 3
) (
   input  logic                                    clk_dsi_i,
   input  logic                                    rst_n_dsi,
   input  logic [dsi_csr_pkg::csr_addr_bits-1:0]   host_a_i,
   input  logic [dsi_csr_pkg::csr_data_bits-1:0]   host_d_i,
   input  logic                                    host_wr_i,
   output logic [dsi_csr_pkg::csr_data_bits-1:0]   host_d_o,
   dsi_lane_ctrl_if.regs                           ctrl,
   output logic                                    clk_en_o,
   output logic                                    clk_invert_o,
   output logic                                    dsi_reset_n_o,
   output logic [dsi_csr_pkg::gpio_bits-1:0]       dsi_gpio_o
);

   localparam int sel_bits = lanes_p * dsi_csr_pkg::lane_sel_bits;

   dsi_csr_pkg::csr_addr_e                    addr;
   logic [dsi_csr_pkg::tick_div_bits-1:0]     tick_div;
   logic [dsi_csr_pkg::tick_div_bits-1:0]     tick_count;
   logic                                      tick;
   logic                                      lp_request;
   logic                                      lp_valid;
   logic                                      lp_accept;
   logic [dsi_csr_pkg::lp_tx_data_bits-1:0]   lp_data;
   logic [sel_bits-1:0]                       lane_sel;
   logic [lanes_p-1:0]                        lane_invert;
   logic [dsi_csr_pkg::csr_data_bits-1:0]     rd_data;

   assign addr = dsi_csr_pkg::csr_addr_e'(host_a_i);

   // a byte is taken only when the lanes are idle and no pulse is pending
   assign lp_accept = host_wr_i && (addr == dsi_csr_pkg::REG_LP_TX) &&
                      host_d_i[dsi_csr_pkg::lp_tx_valid_bit] && ctrl.lp_ready && !lp_valid;

   ////////////////////////////////////////
   // tick divider, period tick_div+1
   ////////////////////////////////////////

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         tick_count <= '0;
         tick       <= 1'b0;
      end else if (tick_count >= tick_div) begin
         tick_count <= '0;
         tick       <= 1'b1;
      end else begin
         tick_count <= tick_count + 1'b1;
         tick       <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // register writes
   ////////////////////////////////////////

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         tick_div      <= '0;
         clk_en_o      <= 1'b0;
         lp_request    <= 1'b0;
         lp_valid      <= 1'b0;
         dsi_reset_n_o <= 1'b0;
         dsi_gpio_o    <= '0;
         lane_sel      <= '0;
         lane_invert   <= '0;
         clk_invert_o  <= 1'b0;
      end else begin
         // lp_valid is a single-cycle strobe
         lp_valid <= lp_accept;
         if (host_wr_i) begin
            case (addr)
               dsi_csr_pkg::REG_TICK_DIV: begin
                  tick_div <= host_d_i[dsi_csr_pkg::tick_div_bits-1:0];
               end
               dsi_csr_pkg::REG_DSI_CTL: begin
                  clk_en_o   <= host_d_i[dsi_csr_pkg::ctl_clk_en_bit];
                  lp_request <= host_d_i[dsi_csr_pkg::ctl_lp_req_bit];
               end
               dsi_csr_pkg::REG_GPIO: begin
                  dsi_reset_n_o <= host_d_i[dsi_csr_pkg::gpio_reset_bit];
                  dsi_gpio_o    <= host_d_i[dsi_csr_pkg::gpio_lsb +: dsi_csr_pkg::gpio_bits];
               end
               dsi_csr_pkg::REG_LANE_CTRL: begin
                  lane_sel     <= host_d_i[dsi_csr_pkg::lane_sel_lsb +: sel_bits];
                  lane_invert  <= host_d_i[dsi_csr_pkg::lane_inv_lsb +: lanes_p];
                  clk_invert_o <= host_d_i[dsi_csr_pkg::clk_inv_bit];
               end
               default: begin
               end
            endcase
         end
      end
   end

   // escape byte payload
   always_ff @(posedge clk_dsi_i) begin
      if (lp_accept) begin
         lp_data <= host_d_i[dsi_csr_pkg::lp_tx_data_lsb +: dsi_csr_pkg::lp_tx_data_bits];
      end
   end

   ////////////////////////////////////////
   // readback
   ////////////////////////////////////////

   always_comb begin
      rd_data = '0;
      case (addr)
         dsi_csr_pkg::REG_TICK_DIV: begin
            rd_data[dsi_csr_pkg::tick_div_bits-1:0] = tick_div;
         end
         dsi_csr_pkg::REG_DSI_CTL: begin
            rd_data[dsi_csr_pkg::ctl_clk_en_bit] = clk_en_o;
            rd_data[dsi_csr_pkg::ctl_lp_req_bit] = ctrl.lp_ready;
         end
         dsi_csr_pkg::REG_LP_TX: begin
            rd_data[dsi_csr_pkg::lp_tx_data_lsb +: dsi_csr_pkg::lp_tx_data_bits] = lp_data;
            rd_data[dsi_csr_pkg::lp_tx_valid_bit] = lp_valid;
         end
         dsi_csr_pkg::REG_GPIO: begin
            rd_data[dsi_csr_pkg::gpio_reset_bit] = dsi_reset_n_o;
            rd_data[dsi_csr_pkg::gpio_lsb +: dsi_csr_pkg::gpio_bits] = dsi_gpio_o;
         end
         dsi_csr_pkg::REG_LANE_CTRL: begin
            rd_data[dsi_csr_pkg::lane_sel_lsb +: sel_bits] = lane_sel;
            rd_data[dsi_csr_pkg::lane_inv_lsb +: lanes_p]  = lane_invert;
            rd_data[dsi_csr_pkg::clk_inv_bit]              = clk_invert_o;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         host_d_o <= '0;
      end else if (!host_wr_i) begin
         host_d_o <= rd_data;
      end
   end

   assign ctrl.tick        = tick;
   assign ctrl.lp_request  = lp_request;
   assign ctrl.lp_valid    = lp_valid;
   assign ctrl.lp_data     = lp_data;
   assign ctrl.lane_sel    = lane_sel;
   assign ctrl.lane_invert = lane_invert;

   // lane 0 is still idle while the strobe is high
   a_valid_needs_ready: assert property (
      @(posedge clk_dsi_i) disable iff (!rst_n_dsi)
      ctrl.lp_valid |-> ctrl.lp_ready
   );

endmodule

`default_nettype wire

/* source/dsi_lp_lane.sv */
`default_nettype none

module dsi_lp_lane #(
   parameter int lane_idx_p = 0
) (
   input  logic              clk_dsi_i,
   input  logic              rst_n_dsi,
   dsi_lane_ctrl_if.lane     ctrl,
   output logic              lp_p_o,
   output logic              lp_n_o,
   output logic              lp_oe_o
);

   localparam logic [dsi_phy_pkg::lane_bit_cnt_bits-1:0] last_bit =
      dsi_phy_pkg::lane_bit_cnt_bits'(dsi_phy_pkg::lane_byte_bits - 1);

   dsi_phy_pkg::lp_lane_state_e                    state;
   logic [dsi_phy_pkg::lane_byte_bits-1:0]         shift_q;
   logic [dsi_phy_pkg::lane_bit_cnt_bits-1:0]      bit_cnt;
   // high once the first tick after capture has put bit 0 on the pins
   logic                                           driving;
   logic                                           selected;
   logic                                           invert;
   logic                                           line;

   assign selected = ctrl.lane_sel[lane_idx_p*dsi_csr_pkg::lane_sel_bits +:
                                   dsi_csr_pkg::lane_sel_bits] == '0;
   assign invert   = ctrl.lane_invert[lane_idx_p];

   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         state   <= dsi_phy_pkg::LP_STOP;
         bit_cnt <= '0;
         driving <= 1'b0;
      end else begin
         case (state)
            dsi_phy_pkg::LP_STOP: begin
               if (ctrl.lp_valid && ctrl.lp_request && selected) begin
                  state   <= dsi_phy_pkg::LP_SHIFT;
                  bit_cnt <= '0;
                  driving <= 1'b0;
               end
            end
            dsi_phy_pkg::LP_SHIFT: begin
               if (ctrl.tick) begin
                  if (!driving) begin
                     driving <= 1'b1;
                  end else if (bit_cnt == last_bit) begin
                     // eighth bit done, back to stop
                     state   <= dsi_phy_pkg::LP_STOP;
                     driving <= 1'b0;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            default: begin
               state <= dsi_phy_pkg::LP_STOP;
            end
         endcase
      end
   end

   // LSB goes out first
   always_ff @(posedge clk_dsi_i) begin
      if (state == dsi_phy_pkg::LP_STOP) begin
         shift_q <= ctrl.lp_data;
      end else if (ctrl.tick && driving) begin
         shift_q <= shift_q >> 1;
      end
   end

   assign line    = shift_q[0] ^ invert;
   assign lp_p_o  = driving ? line  : dsi_phy_pkg::lp_stop_line;
   assign lp_n_o  = driving ? ~line : dsi_phy_pkg::lp_stop_line;
   assign lp_oe_o = ctrl.lp_request;

   if (lane_idx_p == 0) begin : g_ready
      assign ctrl.lp_ready = (state == dsi_phy_pkg::LP_STOP);
   end

   // every tick inside a byte leaves a differential bit on the pins
   a_diff_while_shifting: assert property (
      @(posedge clk_dsi_i) disable iff (!rst_n_dsi)
      $past(ctrl.tick && state == dsi_phy_pkg::LP_SHIFT) && state == dsi_phy_pkg::LP_SHIFT
         |-> lp_p_o != lp_n_o
   );

endmodule

`default_nettype wire

/* source/dsi_clock_lane.sv */
`default_nettype none

module dsi_clock_lane (
   input  logic                                   clk_dsi_i,
   input  logic                                   rst_n_dsi,
   input  logic                                   tick_i,
   input  logic                                   clk_en_i,
   input  logic                                   clk_invert_i,
   output logic [dsi_phy_pkg::lane_byte_bits-1:0] serdes_data_o,
   output logic                                   serdes_oe_o,
   output logic                                   lp_p_o,
   output logic                                   lp_n_o,
   output logic                                   lp_oe_o
);

   dsi_phy_pkg::clk_lane_state_e state;
   logic                         in_hs;

   // all transitions happen on a tick
   always_ff @(posedge clk_dsi_i) begin
      if (!rst_n_dsi) begin
         state <= dsi_phy_pkg::CLK_LP;
      end else if (tick_i) begin
         case (state)
            dsi_phy_pkg::CLK_LP: begin
               if (clk_en_i) begin
                  state <= dsi_phy_pkg::CLK_HS_REQ;
               end
            end
            dsi_phy_pkg::CLK_HS_REQ: begin
               state <= clk_en_i ? dsi_phy_pkg::CLK_HS : dsi_phy_pkg::CLK_LP;
            end
            default: begin
               if (!clk_en_i) begin
                  state <= dsi_phy_pkg::CLK_LP;
               end
            end
         endcase
      end
   end

   assign in_hs = (state == dsi_phy_pkg::CLK_HS);

   assign serdes_data_o = !in_hs ? '0 :
                          clk_invert_i ? ~dsi_phy_pkg::clk_hs_pattern :
                          dsi_phy_pkg::clk_hs_pattern;
   assign serdes_oe_o   = in_hs;

   // LP driver owns the pins from enable until HS starts
   assign lp_oe_o = clk_en_i && !in_hs;
   assign lp_p_o  = in_hs ? dsi_phy_pkg::lp_hs_line : dsi_phy_pkg::lp_stop_line;
   assign lp_n_o  = in_hs ? dsi_phy_pkg::lp_hs_line : dsi_phy_pkg::lp_stop_line;

   // LP oe is released in the same cycle that HS takes the pins
   a_oe_exclusive: assert property (
      @(posedge clk_dsi_i) disable iff (!rst_n_dsi)
      $rose(serdes_oe_o) |-> !lp_oe_o && $past(lp_oe_o)
   );

endmodule

`default_nettype wire

/* source/dsi_core.sv */
`default_nettype none

module dsi_core #(
   parameter int lanes_p = 3
) (
   input  logic                                   clk_dsi_i,
   input  logic                                   rst_n_dsi,

   input  logic [dsi_csr_pkg::csr_addr_bits-1:0]  host_a_i,
   input  logic [dsi_csr_pkg::csr_data_bits-1:0]  host_d_i,
   input  logic                                   host_wr_i,
   output logic [dsi_csr_pkg::csr_data_bits-1:0]  host_d_o,

   // clock lane byte to the serdes
   output logic [dsi_phy_pkg::lane_byte_bits-1:0] serdes_data_o,
   output logic                                   serdes_oe_o,

   output logic [lanes_p-1:0]                     dsi_lp_p_o,
   output logic [lanes_p-1:0]                     dsi_lp_n_o,
   output logic [lanes_p-1:0]                     dsi_lp_oe_o,

   output logic                                   dsi_clk_lp_p_o,
   output logic                                   dsi_clk_lp_n_o,
   output logic                                   dsi_clk_lp_oe_o,

   output logic                                   dsi_reset_n_o,
   output logic [dsi_csr_pkg::gpio_bits-1:0]      dsi_gpio_o
);

   logic clk_en;
   logic clk_invert;

   dsi_lane_ctrl_if #(.lanes_p(lanes_p)) lane_ctrl ();

   ////////////////////////////////////////
   // host registers
   ////////////////////////////////////////

   dsi_host_regs #(
      .lanes_p (lanes_p)
   ) u_regs (
      .clk_dsi_i     (clk_dsi_i),
      .rst_n_dsi     (rst_n_dsi),
      .host_a_i      (host_a_i),
      .host_d_i      (host_d_i),
      .host_wr_i     (host_wr_i),
      .host_d_o      (host_d_o),
      .ctrl          (lane_ctrl.regs),
      .clk_en_o      (clk_en),
      .clk_invert_o  (clk_invert),
      .dsi_reset_n_o (dsi_reset_n_o),
      .dsi_gpio_o    (dsi_gpio_o)
   );

   ////////////////////////////////////////
   // data lanes
   ////////////////////////////////////////

   for (genvar i = 0; i < lanes_p; i++) begin : g_lane
      dsi_lp_lane #(
         .lane_idx_p (i)
      ) u_lane (
         .clk_dsi_i (clk_dsi_i),
         .rst_n_dsi (rst_n_dsi),
         .ctrl      (lane_ctrl.lane),
         .lp_p_o    (dsi_lp_p_o[i]),
         .lp_n_o    (dsi_lp_n_o[i]),
         .lp_oe_o   (dsi_lp_oe_o[i])
      );
   end

   // clock lane
   dsi_clock_lane u_clk_lane (
      .clk_dsi_i     (clk_dsi_i),
      .rst_n_dsi     (rst_n_dsi),
      .tick_i        (lane_ctrl.tick),
      .clk_en_i      (clk_en),
      .clk_invert_i  (clk_invert),
      .serdes_data_o (serdes_data_o),
      .serdes_oe_o   (serdes_oe_o),
      .lp_p_o        (dsi_clk_lp_p_o),
      .lp_n_o        (dsi_clk_lp_n_o),
      .lp_oe_o       (dsi_clk_lp_oe_o)
   );

endmodule

`default_nettype wire

/* bench/dsi_checker.sv */
`default_nettype none

module dsi_checker #(
   parameter int lanes_p = 3
) (
   input  logic                                   clk_i,
   input  logic [dsi_csr_pkg::csr_data_bits-1:0]  host_d_i,
   input  logic [lanes_p-1:0]                     lp_p_i,
   input  logic [lanes_p-1:0]                     lp_n_i,
   input  logic [lanes_p-1:0]                     lp_oe_i,
   input  logic [dsi_phy_pkg::lane_byte_bits-1:0] serdes_data_i,
   input  logic                                   serdes_oe_i,
   input  logic                                   clk_lp_p_i,
   input  logic                                   clk_lp_n_i,
   input  logic                                   clk_lp_oe_i,
   input  logic                                   reset_n_i,
   input  logic [dsi_csr_pkg::gpio_bits-1:0]      gpio_i,
   output int                                     err_count_o
);

   int error_total  = 0;
   int test_errors  = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   assign err_count_o = error_total;

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      if (exp !== act) begin
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
         error_total++;
         test_errors++;
      end
   endtask

   task automatic note_failure(input string msg);
      $display("ERROR %s", msg);
      error_total++;
      test_errors++;
   endtask

   ////////////////////////////////////////
   // per-test bookkeeping
   ////////////////////////////////////////

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   task automatic print_totals();
      $display("totals: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
               error_total);
   endtask

   // readback is registered, sample it mid-cycle
   task automatic check_read(input string name, input logic [31:0] exp);
      @(negedge clk_i);
      compare_value(name, exp, host_d_i);
   endtask

   task automatic check_gpio_pins(input string name, input logic exp_reset,
                                  input logic [dsi_csr_pkg::gpio_bits-1:0] exp_gpio);
      @(negedge clk_i);
      compare_value(name, 32'({exp_gpio, exp_reset}), 32'({gpio_i, reset_n_i}));
   endtask

   // every data lane enables its LP driver with the request
   task automatic check_lane_oe(input string name, input logic exp_req);
      @(negedge clk_i);
      compare_value(name, 32'({lanes_p{exp_req}}), 32'(lp_oe_i));
   endtask

   ////////////////////////////////////////
   // escape byte on the LP pins
   ////////////////////////////////////////

   task automatic check_escape_byte(input string name, input logic [7:0] lp_byte,
                                    input logic [lanes_p-1:0] sel_mask,
                                    input logic [lanes_p-1:0] inv_mask, input int period);
      int   waited;
      logic exp_p;
      logic exp_n;
      waited = 0;
      @(negedge clk_i);
      while (lp_p_i[0] === lp_n_i[0] && waited < 4 * period + 8) begin
         @(negedge clk_i);
         waited++;
      end
      if (lp_p_i[0] === lp_n_i[0]) begin
         note_failure($sformatf("%s: lane 0 never started sending its byte", name));
      end else begin
         // move to the middle of bit 0
         repeat (period / 2) @(negedge clk_i);
         for (int b = 0; b <= 8; b++) begin
            for (int l = 0; l < lanes_p; l++) begin
               // index 8 is the stop state after the last bit
               exp_p = 1'b1;
               exp_n = 1'b1;
               if (sel_mask[l] && b < 8) begin
                  exp_p = lp_byte[b] ^ inv_mask[l];
                  exp_n = ~exp_p;
               end
               compare_value($sformatf("%s lane %0d bit %0d", name, l, b),
                             32'({exp_p, exp_n}), 32'({lp_p_i[l], lp_n_i[l]}));
            end
            if (b < 8) begin
               repeat (period) @(negedge clk_i);
            end
         end
      end
   endtask

   task automatic check_lanes_idle(input string name, input int cycles);
      int start_errors;
      start_errors = test_errors;
      for (int i = 0; i < cycles && test_errors == start_errors; i++) begin
         @(negedge clk_i);
         compare_value(name, 32'({2 * lanes_p{1'b1}}), 32'({lp_p_i, lp_n_i}));
      end
   endtask

   ////////////////////////////////////////
   // clock lane
   ////////////////////////////////////////

   task automatic wait_clock_hs(input string name, input logic [7:0] exp_pattern,
                                input int limit);
      int waited;
      waited = 0;
      @(negedge clk_i);
      while (serdes_oe_i !== 1'b1 && waited < limit) begin
         @(negedge clk_i);
         waited++;
      end
      if (serdes_oe_i !== 1'b1) begin
         note_failure($sformatf("%s: serdes enable did not rise within %0d cycles", name,
                                limit));
      end else begin
         compare_value({name, " pattern"}, 32'(exp_pattern), 32'(serdes_data_i));
         compare_value({name, " lp oe"}, 32'(1'b0), 32'(clk_lp_oe_i));
      end
   endtask

   task automatic wait_clock_lp(input string name, input int limit);
      int waited;
      waited = 0;
      @(negedge clk_i);
      while (serdes_oe_i !== 1'b0 && waited < limit) begin
         @(negedge clk_i);
         waited++;
      end
      if (serdes_oe_i !== 1'b0) begin
         note_failure($sformatf("%s: serdes enable did not fall within %0d cycles", name,
                                limit));
      end else begin
         compare_value({name, " data"}, 32'(0), 32'(serdes_data_i));
         // back at LP stop
         compare_value({name, " lp pins"}, 32'(2'b11), 32'({clk_lp_p_i, clk_lp_n_i}));
      end
   endtask

endmodule

`default_nettype wire

/* bench/tb_dsi_core.sv */
`default_nettype none

module tb_dsi_core;

   localparam int lanes_p = 3;
   // 5 tests, at most 8 bytes of 9 bits at 8 cycles per bit, plus margin
   localparam int cycle_limit = 20000;

   logic                                   clk_dsi;
   logic                                   rst_n_dsi;
   logic [dsi_csr_pkg::csr_addr_bits-1:0]  host_a;
   logic [dsi_csr_pkg::csr_data_bits-1:0]  host_d;
   logic                                   host_wr;
   logic [dsi_csr_pkg::csr_data_bits-1:0]  host_rd;
   logic [dsi_phy_pkg::lane_byte_bits-1:0] serdes_data;
   logic                                   serdes_oe;
   logic [lanes_p-1:0]                     lp_p;
   logic [lanes_p-1:0]                     lp_n;
   logic [lanes_p-1:0]                     lp_oe;
   logic                                   clk_lp_p;
   logic                                   clk_lp_n;
   logic                                   clk_lp_oe;
   logic                                   reset_n;
   logic [dsi_csr_pkg::gpio_bits-1:0]      gpio;
   int                                     errors;
   int                                     cycles = 0;

   // register model
   integer      seed;
   int          period;
   logic        clk_en_m;
   logic        lp_req_m;
   logic [31:0] lane_m;
   logic [31:0] gpio_m;
   logic [31:0] lane_mask;
   logic [31:0] exp_ctl;
   logic [7:0]  lp_byte;
   logic [7:0]  exp_clk;

   dsi_core #(.lanes_p(lanes_p)) dut0 (
      .clk_dsi_i       (clk_dsi),
      .rst_n_dsi       (rst_n_dsi),
      .host_a_i        (host_a),
      .host_d_i        (host_d),
      .host_wr_i       (host_wr),
      .host_d_o        (host_rd),
      .serdes_data_o   (serdes_data),
      .serdes_oe_o     (serdes_oe),
      .dsi_lp_p_o      (lp_p),
      .dsi_lp_n_o      (lp_n),
      .dsi_lp_oe_o     (lp_oe),
      .dsi_clk_lp_p_o  (clk_lp_p),
      .dsi_clk_lp_n_o  (clk_lp_n),
      .dsi_clk_lp_oe_o (clk_lp_oe),
      .dsi_reset_n_o   (reset_n),
      .dsi_gpio_o      (gpio)
   );

   dsi_checker #(.lanes_p(lanes_p)) chk0 (
      .clk_i         (clk_dsi),
      .host_d_i      (host_rd),
      .lp_p_i        (lp_p),
      .lp_n_i        (lp_n),
      .lp_oe_i       (lp_oe),
      .serdes_data_i (serdes_data),
      .serdes_oe_i   (serdes_oe),
      .clk_lp_p_i    (clk_lp_p),
      .clk_lp_n_i    (clk_lp_n),
      .clk_lp_oe_i   (clk_lp_oe),
      .reset_n_i     (reset_n),
      .gpio_i        (gpio),
      .err_count_o   (errors)
   );

   initial begin
      clk_dsi = 1'b0;
      forever #2 clk_dsi = ~clk_dsi;
   end

   always @(posedge clk_dsi) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run went past %0d cycles", cycle_limit);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic write_reg(input dsi_csr_pkg::csr_addr_e addr, input logic [31:0] data);
      @(posedge clk_dsi);
      host_a  <= addr;
      host_d  <= data;
      host_wr <= 1'b1;
      @(posedge clk_dsi);
      host_wr <= 1'b0;
   endtask

   task automatic read_expect(input string name, input dsi_csr_pkg::csr_addr_e addr,
                              input logic [31:0] exp);
      @(posedge clk_dsi);
      host_a <= addr;
      @(posedge clk_dsi);
      chk0.check_read(name, exp);
   endtask

   task automatic set_ctl(input logic en, input logic req);
      logic [31:0] data;
      clk_en_m = en;
      lp_req_m = req;
      data = '0;
      data[dsi_csr_pkg::ctl_clk_en_bit] = en;
      data[dsi_csr_pkg::ctl_lp_req_bit] = req;
      write_reg(dsi_csr_pkg::REG_DSI_CTL, data);
   endtask

   task automatic set_tick_div();
      period = int'($unsigned($random(seed)) % 8) + 1;
      write_reg(dsi_csr_pkg::REG_TICK_DIV, 32'(period - 1));
   endtask

   function automatic logic [lanes_p-1:0] selected_lanes(input logic [31:0] lane_ctrl);
      logic [lanes_p-1:0] mask;
      for (int l = 0; l < lanes_p; l++) begin
         mask[l] = lane_ctrl[dsi_csr_pkg::lane_sel_lsb + l * dsi_csr_pkg::lane_sel_bits +:
                             dsi_csr_pkg::lane_sel_bits] == '0;
      end
      return mask;
   endfunction

   function automatic logic [lanes_p-1:0] inverted_lanes(input logic [31:0] lane_ctrl);
      return lane_ctrl[dsi_csr_pkg::lane_inv_lsb +: lanes_p];
   endfunction

   // LP_TX payload with the valid bit set
   function automatic logic [31:0] tx_word(input logic [7:0] data);
      logic [31:0] word;
      word = 32'(data);
      word[dsi_csr_pkg::lp_tx_valid_bit] = 1'b1;
      return word;
   endfunction

   initial begin
      seed      = 32'h2951_42e9;
      host_a    = '0;
      host_d    = '0;
      host_wr   = 1'b0;
      rst_n_dsi = 1'b0;
      clk_en_m  = 1'b0;
      lp_req_m  = 1'b0;
      period    = 1;
      lane_mask = ((32'd1 << (lanes_p * dsi_csr_pkg::lane_sel_bits)) - 1) |
                  (((32'd1 << lanes_p) - 1) << dsi_csr_pkg::lane_inv_lsb) |
                  (32'd1 << dsi_csr_pkg::clk_inv_bit);
      repeat (8) @(posedge clk_dsi);
      rst_n_dsi <= 1'b1;

      ////////////////////////////////////////
      // register readback and GPIO pins
      ////////////////////////////////////////
      for (int i = 0; i < 4; i++) begin
         set_tick_div();
         lane_m = $random(seed);
         gpio_m = $random(seed);
         write_reg(dsi_csr_pkg::REG_LANE_CTRL, lane_m);
         write_reg(dsi_csr_pkg::REG_GPIO, gpio_m);
         read_expect("readback tick_div", dsi_csr_pkg::REG_TICK_DIV, 32'(period - 1));
         read_expect("readback lane_ctrl", dsi_csr_pkg::REG_LANE_CTRL, lane_m & lane_mask);
         read_expect("readback gpio", dsi_csr_pkg::REG_GPIO, gpio_m & 32'hf);
      end
      chk0.finish_test("readback");

      for (int i = 0; i < 4; i++) begin
         gpio_m = $random(seed);
         write_reg(dsi_csr_pkg::REG_GPIO, gpio_m);
         chk0.check_gpio_pins("gpio", gpio_m[0], gpio_m[3:1]);
      end
      chk0.finish_test("gpio");

      ////////////////////////////////////////
      // escape bytes on the data lanes
      ////////////////////////////////////////
      set_tick_div();
      lane_m = $random(seed);
      lane_m[dsi_csr_pkg::lane_sel_lsb +: 2] = 2'b00;
      lane_m[dsi_csr_pkg::lane_inv_lsb +: lanes_p] = '0;
      write_reg(dsi_csr_pkg::REG_LANE_CTRL, lane_m);
      chk0.check_lane_oe("lane oe", lp_req_m);
      set_ctl(1'b0, 1'b1);
      chk0.check_lane_oe("lane oe", lp_req_m);
      exp_ctl = '0;
      exp_ctl[dsi_csr_pkg::ctl_lp_req_bit] = 1'b1;
      for (int i = 0; i < 3; i++) begin
         lp_byte = $random(seed);
         write_reg(dsi_csr_pkg::REG_LP_TX, tx_word(lp_byte));
         chk0.check_escape_byte("escape", lp_byte, selected_lanes(lane_m),
                                inverted_lanes(lane_m), period);
         read_expect("escape lp ready", dsi_csr_pkg::REG_DSI_CTL, exp_ctl);
      end
      chk0.finish_test("escape");

      // lanes 0 and 1 selected, lane 1 inverted, lane 2 parked
      set_tick_div();
      lane_m = $random(seed);
      lane_m[5:0] = {2'(1 + $unsigned($random(seed)) % 3), 4'b0000};
      lane_m[dsi_csr_pkg::lane_inv_lsb +: 2] = 2'b10;
      write_reg(dsi_csr_pkg::REG_LANE_CTRL, lane_m);
      for (int i = 0; i < 2; i++) begin
         lp_byte = $random(seed);
         write_reg(dsi_csr_pkg::REG_LP_TX, tx_word(lp_byte));
         // lands while lane 0 is busy
         write_reg(dsi_csr_pkg::REG_LP_TX, tx_word(~lp_byte));
         chk0.check_escape_byte("lane select", lp_byte, selected_lanes(lane_m),
                                inverted_lanes(lane_m), period);
         chk0.check_lanes_idle("ignored write", 12 * period);
         read_expect("lane select lp ready", dsi_csr_pkg::REG_DSI_CTL, exp_ctl);
      end
      chk0.finish_test("lane_select");

      ////////////////////////////////////////
      // clock lane
      ////////////////////////////////////////
      for (int i = 0; i < 2; i++) begin
         set_tick_div();
         lane_m[dsi_csr_pkg::clk_inv_bit] = (i == 0) ^ lane_m[0];
         write_reg(dsi_csr_pkg::REG_LANE_CTRL, lane_m);
         exp_clk = lane_m[dsi_csr_pkg::clk_inv_bit] ? 8'h55 : 8'haa;
         set_ctl(1'b1, lp_req_m);
         chk0.wait_clock_hs("clock on", exp_clk, 3 * period + 2);
         set_ctl(1'b0, lp_req_m);
         chk0.wait_clock_lp("clock off", 3 * period + 2);
      end
      chk0.finish_test("clock_lane");

      chk0.print_totals();
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
source/dsi_csr_pkg.sv
source/dsi_phy_pkg.sv
source/dsi_lane_ctrl_if.sv
source/dsi_host_regs.sv
source/dsi_lp_lane.sv
source/dsi_clock_lane.sv
source/dsi_core.sv
bench/dsi_checker.sv
bench/tb_dsi_core.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dsi_core -f src.f -o tb_dsi_core \
   && ./obj_dir/tb_dsi_core > sim.log 2>&1 \
   || echo "run.sh: build or simulation error"
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && echo "run.sh: pass" && exit 0 \
   || { echo "run.sh: fail"; exit 1; }
